// ==== run.sh ====
#!/bin/sh
# Build and run the fetch stage testbench with Verilator
# Exit status is nonzero when the build or the simulation fails
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module if_stage_tb \
  -f src.f -o if_stage_sim \
  && ./obj_dir/if_stage_sim \
  || { echo "simulation failed"; exit 1; }

// ==== src.f ====
src/if_pkg.sv
src/if_prefetch_unit.sv
src/if_fetch_fifo.sv
src/if_id_pipe.sv
src/if_stage.sv
tb/if_stage_assertions.sv
tb/if_stage_tb.sv

// ==== src/if_fetch_fifo.sv ====
/*
  Small synchronous FIFO between prefetcher and IF/ID register.
  Payload type is set through entry_t. Flush empties it in one cycle and
  wins over a push in the same cycle. free_o already counts a slot that is
  being popped in the current cycle, so the prefetcher can reuse it at once.
*/

module if_fetch_fifo #(
  parameter type entry_t = logic
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     flush_i,
  input  logic                     push_i,
  input  entry_t                   push_data_i,
  input  logic                     pop_i,
  output entry_t                   pop_data_o,
  output logic                     empty_o,
  output logic [if_pkg::CNT_W-1:0] free_o
);

  typedef logic [if_pkg::CNT_W-1:0] cnt_t;
  typedef logic [if_pkg::PTR_W-1:0] ptr_t;

  // Storage, no reset needed
  entry_t mem_q [if_pkg::FIFO_DEPTH];
  ptr_t   wr_ptr_q;
  ptr_t   rd_ptr_q;
  cnt_t   count_q;
  logic   push_en;
  logic   pop_en;

  assign empty_o = (count_q == '0);

  // Popped slot counts as free in the same cycle
  assign free_o = cnt_t'(if_pkg::FIFO_DEPTH) - count_q + cnt_t'(pop_en);

  // Flush blocks both ports, full FIFO refuses a push
  assign pop_en  = pop_i && !empty_o && !flush_i;
  assign push_en = push_i && !flush_i && (free_o != '0);

  // Head entry, valid whenever the FIFO is not empty
  assign pop_data_o = mem_q[rd_ptr_q];

  //////////////////////////////
  // Pointers and occupancy
  //////////////////////////////

  // Depth is a power of two so pointers wrap on their own
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_en) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_en) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      count_q <= count_q + cnt_t'(push_en) - cnt_t'(pop_en);
    end
  end

  // Data write
  always_ff @(posedge clk) begin
    if (push_en) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

endmodule

// ==== src/if_id_pipe.sv ====
/*
  IF/ID output register.
  Takes the head of the fetch FIFO when it is empty or being consumed by
  decode. Kill drops its contents, halt freezes it and hides the valid flag.
  An entry leaves on a cycle with if_valid_o and id_ready_i both high.
*/

module if_id_pipe (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 halt_i,
  input  logic                 kill_i,
  input  logic                 id_ready_i,
  input  logic                 fifo_empty_i,
  input  if_pkg::fetch_entry_t fifo_data_i,
  output logic                 pop_o,
  output logic                 if_ready_o,
  output logic                 if_valid_o,
  output if_pkg::fetch_entry_t if_entry_o
);

  logic                 valid_q;
  if_pkg::fetch_entry_t entry_q;

  //////////////////////////////
  // Handshake
  //////////////////////////////

  // Kill beats halt, halt beats back-pressure
  always_comb begin
    if (kill_i) begin
      if_ready_o = 1'b1;
    end else if (halt_i) begin
      if_ready_o = 1'b0;
    end else begin
      // Free, or current entry leaves this cycle
      if_ready_o = !valid_q || id_ready_i;
    end
  end

  // No load under kill, the FIFO is flushed in the same cycle
  assign pop_o = if_ready_o && !kill_i && !fifo_empty_i;

  // Valid hidden while halted or killed
  assign if_valid_o = valid_q && !halt_i && !kill_i;
  assign if_entry_o = entry_q;

  //////////////////////////////
  // Register
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (kill_i) begin
      valid_q <= 1'b0;
    end else if (if_ready_o) begin
      // Either reload from FIFO or drain to empty
      valid_q <= !fifo_empty_i;
    end
  end

  // Payload only moves on a pop
  always_ff @(posedge clk) begin
    if (pop_o) begin
      entry_q <= fifo_data_i;
    end
  end

endmodule

// ==== src/if_pkg.sv ====
/*
  Shared definitions for the instruction fetch stage.
  Holds the privilege level encoding, the fetch entry carried from the
  prefetcher through the FIFO to the IF/ID register, and the sizing and
  reset constants. Design and testbench files refer to these by scoped name.
*/

package if_pkg;

  //////////////////////////////
  // Privilege levels
  //////////////////////////////

  // Encoding follows the RISC-V privileged spec, 2'b10 is reserved
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_S = 2'b01,
    PRIV_LVL_M = 2'b11
  } priv_lvl_t;

  //////////////////////////////
  // Fetch entry
  //////////////////////////////

  // Word address, instruction word and stream privilege, 66 bits in total
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] instr;
    priv_lvl_t   priv_lvl;
  } fetch_entry_t;

  //////////////////////////////
  // Sizing and reset values
  //////////////////////////////

  // FIFO entries, also the cap on requests in flight
  localparam int unsigned FIFO_DEPTH = 4;
  // Wide enough to hold FIFO_DEPTH itself
  localparam int unsigned CNT_W      = 3;
  // FIFO read and write pointer width
  localparam int unsigned PTR_W      = $clog2(FIFO_DEPTH);

  // First fetch after reset
  localparam logic [31:0] RESET_ADDR = 32'h0000_0080;
  localparam priv_lvl_t   RESET_PRIV = PRIV_LVL_M;

endpackage

// ==== src/if_prefetch_unit.sv ====
/*
  Prefetcher for the fetch stage.
  Issues word-aligned strobe requests while FIFO credit remains, registers
  each returned word with its address and the stream privilege level and
  pushes it into the fetch FIFO one cycle after the response. A redirect
  restarts the stream and marks every unanswered request as stale, so
  those responses are thrown away when they arrive.
*/

module if_prefetch_unit (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        redirect_i,
  input  logic [31:0]                 redirect_addr_i,
  input  if_pkg::priv_lvl_t           redirect_priv_i,
  input  logic                        instr_rvalid_i,
  input  logic [31:0]                 instr_rdata_i,
  input  logic [if_pkg::CNT_W-1:0]    fifo_free_i,
  output logic                        instr_req_o,
  output logic [31:0]                 instr_addr_o,
  output logic                        push_o,
  output if_pkg::fetch_entry_t        push_entry_o,
  output if_pkg::priv_lvl_t           prefetch_priv_lvl_o
);

  typedef logic [if_pkg::CNT_W-1:0] cnt_t;

  // Goes high on the first edge after reset, delays the first request
  logic                 fetch_en_q;
  logic [31:0]          req_addr_q;
  // Address of the next live response
  logic [31:0]          rsp_addr_q;
  cnt_t                 outstanding_q;
  cnt_t                 outstanding_d;
  // Requests of a killed stream still owed by the bus
  cnt_t                 stale_q;
  cnt_t                 stale_d;
  if_pkg::priv_lvl_t    priv_q;
  logic                 push_q;
  if_pkg::fetch_entry_t push_entry_q;
  logic [31:0]          redirect_addr_aligned;
  cnt_t                 in_flight;
  logic                 rsp_live;
  logic                 rsp_stale;

  // Low bits dropped, no compressed support
  assign redirect_addr_aligned = {redirect_addr_i[31:2], 2'b00};

  // Responses are in order, stale ones always come first
  assign rsp_stale = instr_rvalid_i && (stale_q != '0);
  assign rsp_live  = instr_rvalid_i && (stale_q == '0);

  // Everything that will still need a slot or a bus answer
  assign in_flight = outstanding_q + stale_q + cnt_t'(push_q);

  //////////////////////////////
  // Request side
  //////////////////////////////

  assign instr_req_o  = fetch_en_q && !redirect_i && (fifo_free_i > in_flight);
  assign instr_addr_o = req_addr_q;

  // Counter update
  always_comb begin
    outstanding_d = outstanding_q;
    stale_d       = stale_q;
    if (redirect_i) begin
      // Whole old stream becomes stale, minus any answer in this cycle
      outstanding_d = '0;
      stale_d       = stale_q + outstanding_q - cnt_t'(instr_rvalid_i);
    end else begin
      if (instr_req_o) begin
        outstanding_d = outstanding_d + 1'b1;
      end
      if (rsp_live) begin
        outstanding_d = outstanding_d - 1'b1;
      end
      if (rsp_stale) begin
        stale_d = stale_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fetch_en_q    <= 1'b0;
      req_addr_q    <= if_pkg::RESET_ADDR;
      rsp_addr_q    <= if_pkg::RESET_ADDR;
      outstanding_q <= '0;
      stale_q       <= '0;
      priv_q        <= if_pkg::RESET_PRIV;
      push_q        <= 1'b0;
    end else begin
      fetch_en_q    <= 1'b1;
      outstanding_q <= outstanding_d;
      stale_q       <= stale_d;
      // Old-stream answer in a redirect cycle is never pushed
      push_q        <= rsp_live && !redirect_i;
      if (redirect_i) begin
        req_addr_q <= redirect_addr_aligned;
        rsp_addr_q <= redirect_addr_aligned;
        priv_q     <= redirect_priv_i;
      end else begin
        if (instr_req_o) begin
          req_addr_q <= req_addr_q + 32'd4;
        end
        if (rsp_live) begin
          rsp_addr_q <= rsp_addr_q + 32'd4;
        end
      end
    end
  end

  //////////////////////////////
  // Response register
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rsp_live && !redirect_i) begin
      push_entry_q.addr     <= rsp_addr_q;
      push_entry_q.instr    <= instr_rdata_i;
      push_entry_q.priv_lvl <= priv_q;
    end
  end

  assign push_o              = push_q;
  assign push_entry_o        = push_entry_q;
  assign prefetch_priv_lvl_o = priv_q;

endmodule

// ==== src/if_stage.sv ====
/*
  Top level of the instruction fetch stage.
  Connects prefetcher, fetch FIFO and IF/ID register. A redirect pulse
  flushes the FIFO and kills the output register in the same cycle while
  the prefetcher restarts at the new address and privilege level.
*/

module if_stage (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 redirect_i,
  input  logic [31:0]          redirect_addr_i,
  input  if_pkg::priv_lvl_t    redirect_priv_i,
  input  logic                 halt_i,
  input  logic                 id_ready_i,
  input  logic                 instr_rvalid_i,
  input  logic [31:0]          instr_rdata_i,
  output logic                 instr_req_o,
  output logic [31:0]          instr_addr_o,
  output logic                 if_ready_o,
  output logic                 if_valid_o,
  output if_pkg::fetch_entry_t if_entry_o,
  output if_pkg::priv_lvl_t    prefetch_priv_lvl_o
);

  // Prefetcher to FIFO
  logic                       push;
  if_pkg::fetch_entry_t       push_entry;
  logic [if_pkg::CNT_W-1:0]   fifo_free;

  // FIFO to output register
  logic                       pop;
  logic                       fifo_empty;
  if_pkg::fetch_entry_t       fifo_data;

  //////////////////////////////
  // Prefetch
  //////////////////////////////

  if_prefetch_unit u_prefetch (
    .clk                 (clk),
    .rst_n               (rst_n),
    .redirect_i          (redirect_i),
    .redirect_addr_i     (redirect_addr_i),
    .redirect_priv_i     (redirect_priv_i),
    .instr_rvalid_i      (instr_rvalid_i),
    .instr_rdata_i       (instr_rdata_i),
    .fifo_free_i         (fifo_free),
    .instr_req_o         (instr_req_o),
    .instr_addr_o        (instr_addr_o),
    .push_o              (push),
    .push_entry_o        (push_entry),
    .prefetch_priv_lvl_o (prefetch_priv_lvl_o)
  );

  //////////////////////////////
  // Buffer and output
  //////////////////////////////

  // Redirect doubles as flush
  if_fetch_fifo #(
    .entry_t (if_pkg::fetch_entry_t)
  ) u_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush_i     (redirect_i),
    .push_i      (push),
    .push_data_i (push_entry),
    .pop_i       (pop),
    .pop_data_o  (fifo_data),
    .empty_o     (fifo_empty),
    .free_o      (fifo_free)
  );

  // ...and as kill for the output register
  if_id_pipe u_pipe (
    .clk          (clk),
    .rst_n        (rst_n),
    .halt_i       (halt_i),
    .kill_i       (redirect_i),
    .id_ready_i   (id_ready_i),
    .fifo_empty_i (fifo_empty),
    .fifo_data_i  (fifo_data),
    .pop_o        (pop),
    .if_ready_o   (if_ready_o),
    .if_valid_o   (if_valid_o),
    .if_entry_o   (if_entry_o)
  );

endmodule

// ==== tb/if_stage_assertions.sv ====
/*
  Concurrent checks on the fetch stage, bound into if_stage.
  Covers request alignment, the halt and kill behavior of the output
  register, and that the first valid entry after a privilege change
  carries the new level.
*/

module if_stage_assertions (
  input logic                 clk,
  input logic                 rst_n,
  input logic                 redirect_i,
  input logic                 halt_i,
  input logic                 instr_req_i,
  input logic [31:0]          instr_addr_i,
  input logic                 if_ready_i,
  input logic                 if_valid_i,
  input if_pkg::fetch_entry_t if_entry_i,
  input if_pkg::priv_lvl_t    prefetch_priv_i
);

  // Last seen stream level and the level the next valid entry must carry
  if_pkg::priv_lvl_t priv_prev_q;
  if_pkg::priv_lvl_t priv_want_q;
  logic              priv_pending_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      priv_prev_q    <= if_pkg::RESET_PRIV;
      priv_want_q    <= if_pkg::RESET_PRIV;
      priv_pending_q <= 1'b0;
    end else begin
      priv_prev_q <= prefetch_priv_i;
      if (prefetch_priv_i != priv_prev_q) begin
        priv_pending_q <= 1'b1;
        priv_want_q    <= prefetch_priv_i;
      end else if (if_valid_i) begin
        priv_pending_q <= 1'b0;
      end
    end
  end

  //////////////////////////////
  // Properties
  //////////////////////////////

  a_req_aligned : assert property (@(posedge clk) disable iff (!rst_n)
    instr_req_i |-> instr_addr_i[1:0] == 2'b00)
    else $error("fetch request address not word aligned");

  // Halt without kill hides valid and blocks ready
  a_halt : assert property (@(posedge clk) disable iff (!rst_n)
    halt_i && !redirect_i |-> !if_valid_i && !if_ready_i)
    else $error("valid or ready high under halt");

  a_kill : assert property (@(posedge clk) disable iff (!rst_n)
    redirect_i |-> if_ready_i && !if_valid_i)
    else $error("output register not killed by redirect");

  a_priv : assert property (@(posedge clk) disable iff (!rst_n)
    priv_pending_q && if_valid_i |-> if_entry_i.priv_lvl == priv_want_q)
    else $error("first entry after privilege change carries the old level");

endmodule

bind if_stage if_stage_assertions u_assertions (
  .clk             (clk),
  .rst_n           (rst_n),
  .redirect_i      (redirect_i),
  .halt_i          (halt_i),
  .instr_req_i     (instr_req_o),
  .instr_addr_i    (instr_addr_o),
  .if_ready_i      (if_ready_o),
  .if_valid_i      (if_valid_o),
  .if_entry_i      (if_entry_o),
  .prefetch_priv_i (prefetch_priv_lvl_o)
);

// ==== tb/if_stage_tb.sv ====
/*
  Testbench for the instruction fetch stage.
  Runs if_stage against a memory model with random response latency and
  drives back-pressure, halts and redirects on the falling edge. Every
  consumed entry is compared with the expected fetch stream, and a redirect
  restarts the tracked pc and privilege level.
*/

module if_stage_tb;

  localparam int unsigned TIMEOUT_CYCLES = 6000;

  logic                 clk;
  logic                 rst_n;
  logic                 redirect;
  logic [31:0]          redirect_addr;
  if_pkg::priv_lvl_t    redirect_priv;
  logic                 halt;
  logic                 id_ready;
  logic                 instr_rvalid;
  logic [31:0]          instr_rdata;
  logic                 instr_req;
  logic [31:0]          instr_addr;
  logic                 if_ready;
  logic                 if_valid;
  if_pkg::fetch_entry_t if_entry;
  if_pkg::priv_lvl_t    prefetch_priv;

  // Random state and run bookkeeping
  integer               seed;
  int                   cycle_cnt = 0;
  int                   consumed = 0;
  int                   redirect_cnt;
  int                   halt_cycles;
  string                test_name;
  // Position of the stream as seen by decode
  logic [31:0]          exp_pc = if_pkg::RESET_ADDR;
  if_pkg::priv_lvl_t    exp_priv = if_pkg::RESET_PRIV;
  // Memory model, pending addresses and the cycle each answer is due
  logic [31:0]          req_q [$];
  int                   due_q [$];

  if_stage u_dut (
    .clk                 (clk),
    .rst_n               (rst_n),
    .redirect_i          (redirect),
    .redirect_addr_i     (redirect_addr),
    .redirect_priv_i     (redirect_priv),
    .halt_i              (halt),
    .id_ready_i          (id_ready),
    .instr_rvalid_i      (instr_rvalid),
    .instr_rdata_i       (instr_rdata),
    .instr_req_o         (instr_req),
    .instr_addr_o        (instr_addr),
    .if_ready_o          (if_ready),
    .if_valid_o          (if_valid),
    .if_entry_o          (if_entry),
    .prefetch_priv_lvl_o (prefetch_priv)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  // Memory contents, address XOR pattern rotated left by 3
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    logic [31:0] x;
    x = addr ^ 32'h5A5A_0000;
    return {x[28:0], x[31:29]};
  endfunction

  function automatic if_pkg::fetch_entry_t expected_entry(input logic [31:0] pc,
                                                          input if_pkg::priv_lvl_t priv);
    if_pkg::fetch_entry_t e;
    e.addr     = pc;
    e.instr    = mem_word(pc);
    e.priv_lvl = priv;
    return e;
  endfunction

  function automatic int rand_range(input int lo, input int hi);
    logic [31:0] r;
    r = $random(seed);
    return lo + int'(r % 32'(hi - lo + 1));
  endfunction

  function automatic if_pkg::priv_lvl_t random_priv();
    case (rand_range(0, 2))
      0:       return if_pkg::PRIV_LVL_U;
      1:       return if_pkg::PRIV_LVL_S;
      default: return if_pkg::PRIV_LVL_M;
    endcase
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1, "run stopped");
  endtask

  // One test, random inputs per cycle until n_entries are consumed
  task automatic run_test(input string name, input int n_entries, input int ready_pct,
                          input int halt_pct, input int redirect_pct);
    int target;
    int halt_left;
    target    = consumed + n_entries;
    halt_left = 0;
    test_name = name;
    while (consumed < target) begin
      @(negedge clk);
      redirect = 1'b0;
      // Halt comes in stretches of 1 to 8 cycles
      if (halt_left == 0 && rand_range(0, 99) < halt_pct) begin
        halt_left = rand_range(1, 8);
      end
      halt = (halt_left > 0);
      if (halt_left > 0) begin
        halt_left--;
        halt_cycles++;
      end
      id_ready = (rand_range(0, 99) < ready_pct);
      // Unaligned targets too
      if (rand_range(0, 99) < redirect_pct) begin
        redirect      = 1'b1;
        redirect_addr = $random(seed);
        redirect_priv = random_priv();
        redirect_cnt++;
      end
    end
  endtask

  //////////////////////////////
  // Memory model
  //////////////////////////////

  always @(posedge clk) begin
    if (rst_n && instr_req) begin
      req_q.push_back(instr_addr);
      due_q.push_back(cycle_cnt + rand_range(1, 4));
      assert (req_q.size() <= if_pkg::FIFO_DEPTH)
      else fail_run("memory model holds more than FIFO_DEPTH outstanding requests");
    end
  end

  // In-order answers, a late head also holds back the ones behind it
  always @(negedge clk) begin
    if (rst_n && req_q.size() > 0 && cycle_cnt >= due_q[0]) begin
      instr_rvalid = 1'b1;
      instr_rdata  = mem_word(req_q.pop_front());
      void'(due_q.pop_front());
    end else begin
      instr_rvalid = 1'b0;
      instr_rdata  = '0;
    end
  end

  //////////////////////////////
  // Compare and timeout
  //////////////////////////////

  always @(posedge clk) begin : compare_proc
    if_pkg::fetch_entry_t exp;
    if (rst_n) begin
      // Stream level follows the last redirect
      assert (prefetch_priv == exp_priv)
      else fail_run($sformatf("mismatch %s expected priv %h actual priv %h",
                              test_name, exp_priv, prefetch_priv));
      if (redirect) begin
        assert (if_ready && !if_valid)
        else fail_run($sformatf("ready low or valid high on redirect in test %s",
                                test_name));
      end else if (halt) begin
        assert (!if_valid && !if_ready)
        else fail_run($sformatf("valid or ready high under halt in test %s", test_name));
      end
      if (if_valid && id_ready) begin
        exp = expected_entry(exp_pc, exp_priv);
        assert (if_entry == exp)
        else fail_run($sformatf("mismatch %s expected %h actual %h", test_name, exp, if_entry));
        exp_pc = exp_pc + 32'd4;
        consumed++;
      end
      // New stream starts at the target rounded down to a word
      if (redirect) begin
        exp_pc   = redirect_addr & 32'hFFFF_FFFC;
        exp_priv = redirect_priv;
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      fail_run($sformatf("timeout after %0d cycles in test %s", cycle_cnt, test_name));
    end
  end

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    seed          = 32'ha97610db;
    rst_n         = 1'b0;
    redirect      = 1'b0;
    redirect_addr = '0;
    redirect_priv = if_pkg::PRIV_LVL_M;
    halt          = 1'b0;
    id_ready      = 1'b1;
    instr_rvalid  = 1'b0;
    instr_rdata   = '0;
    redirect_cnt  = 0;
    halt_cycles   = 0;
    test_name     = "reset";
    repeat (8) @(negedge clk);
    assert (!instr_req && !if_valid)
    else fail_run("request or valid high while reset is held");
    rst_n = 1'b1;
    run_test("reset_stream", 150, 100, 0, 0);
    run_test("back_pressure", 150, 50, 0, 0);
    run_test("redirect", 100, 100, 0, 6);
    run_test("halt", 120, 100, 10, 0);
    run_test("mixed", 150, 70, 5, 4);
    @(negedge clk);
    redirect = 1'b0;
    halt     = 1'b0;
    if (redirect_cnt > 0 && halt_cycles > 0) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      fail_run("stimulus never issued a redirect or never held halt");
    end
  end

endmodule
